// File: hdl/battleship_pkg.sv
/*
 * Battleship referee shared definitions
 * Board geometry, fleet makeup, cell states and command results
 * used by the referee core
 */
`default_nettype none

package battleship_pkg;

    // --------------------------------------------------
    // Board and fleet geometry
    // --------------------------------------------------
    localparam int BOARD_SIZE  = 10;
    localparam int COORD_W     = 4;
    localparam int NUM_SHIPS   = 5;
    localparam int SHIP_IDX_W  = 3;
    localparam int SHIP_LEN_W  = 3;
    localparam int FLEET_CELLS = 17;
    localparam int HITS_W      = 5;

    // Ship lengths in placement order with entry 0 placed first
    localparam logic [NUM_SHIPS-1:0][SHIP_LEN_W-1:0] SHIP_LENGTHS =
        {3'd2, 3'd3, 3'd3, 3'd4, 3'd5};

    // --------------------------------------------------
    // Cell states and results
    // --------------------------------------------------
    typedef enum logic [1:0] {
        CELL_EMPTY = 2'b00,
        CELL_MISS  = 2'b01,
        CELL_HIT   = 2'b10,
        CELL_SHIP  = 2'b11
    } cell_t;

    typedef enum logic [3:0] {
        RES_PLACED,
        RES_OFF_BOARD,
        RES_OVERLAP,
        RES_WRONG_PLAYER,
        RES_MISS,
        RES_HIT,
        RES_REPEAT,
        RES_WIN,
        RES_GAME_OVER
    } result_t;

endpackage

`default_nettype wire

// File: hdl/board_mem.sv
/*
 * Board memory
 * Holds one player's 10x10 grid of cell states. Writes land at the
 * addressed cell; reads are registered and show up one cycle later.
 */
`timescale 1ns/100ps
`default_nettype none

module board_mem (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                write_enable,
    input  logic                                read_enable,
    input  logic [battleship_pkg::COORD_W-1:0]  row,
    input  logic [battleship_pkg::COORD_W-1:0]  col,
    input  battleship_pkg::cell_t               write_data,
    output battleship_pkg::cell_t               read_data
);
    import battleship_pkg::*;

    cell_t cells [BOARD_SIZE][BOARD_SIZE];

    // Whole grid goes back to empty on reset
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int r = 0; r < BOARD_SIZE; r++)
            begin
                for (int c = 0; c < BOARD_SIZE; c++)
                begin
                    cells[r][c] <= CELL_EMPTY;
                end
            end
        end
        else if (write_enable)
        begin
            cells[row][col] <= write_data;
        end
    end

    // Registered read port
    always_ff @(posedge clk)
    begin
        if (read_enable)
        begin
            read_data <= cells[row][col];
        end
    end

endmodule

`default_nettype wire

// File: hdl/cell_walker.sv
/*
 * Cell walker
 * Steps a board address along a ship's path, one cell per step,
 * and decides at load time whether the whole run fits on the board
 */
`timescale 1ns/100ps
`default_nettype none

module cell_walker (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   walk_start,
    input  logic                                   step,
    input  logic                                   direction,
    input  logic [battleship_pkg::COORD_W-1:0]     start_row,
    input  logic [battleship_pkg::COORD_W-1:0]     start_col,
    input  logic [battleship_pkg::SHIP_LEN_W-1:0]  ship_len,
    output logic [battleship_pkg::COORD_W-1:0]     row,
    output logic [battleship_pkg::COORD_W-1:0]     col,
    output logic                                   on_board,
    output logic                                   walk_last
);
    import battleship_pkg::*;

    logic [SHIP_LEN_W-1:0] count;
    logic [COORD_W:0]      run_end;
    logic                  fits;

    // One past the far end of the run along the walk direction
    assign run_end = (direction ? {1'b0, start_col} : {1'b0, start_row})
                     + {{(COORD_W + 1 - SHIP_LEN_W){1'b0}}, ship_len};

    assign fits = (start_row < COORD_W'(BOARD_SIZE)) &&
                  (start_col < COORD_W'(BOARD_SIZE)) &&
                  (run_end <= (COORD_W + 1)'(BOARD_SIZE));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            row      <= '0;
            col      <= '0;
            count    <= '0;
            on_board <= 1'b0;
        end
        else if (walk_start)
        begin
            row      <= start_row;
            col      <= start_col;
            count    <= '0;
            on_board <= fits;
        end
        else if (step)
        begin
            // Horizontal runs move along the column
            if (direction)
                col <= col + 1'b1;
            else
                row <= row + 1'b1;
            count <= count + 1'b1;
        end
    end

    assign walk_last = (count == ship_len - 1'b1);

endmodule

`default_nettype wire

// File: hdl/fleet_tracker.sv
/*
 * Fleet tracker
 * Counts ships placed and ship cells still standing for each player.
 * Supplies the length of the selected player's next ship.
 */
`timescale 1ns/100ps
`default_nettype none

module fleet_tracker (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   sel_player,
    input  logic                                   ship_placed,
    input  logic                                   hit_scored,
    output logic [battleship_pkg::SHIP_LEN_W-1:0]  ship_len,
    output logic                                   fleet_placed,
    output logic                                   fleet_sunk
);
    import battleship_pkg::*;

    logic [SHIP_IDX_W-1:0] ship_idx  [2];
    logic [HITS_W-1:0]     hits_left [2];

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int p = 0; p < 2; p++)
            begin
                ship_idx[p]  <= '0;
                hits_left[p] <= HITS_W'(FLEET_CELLS);
            end
        end
        else
        begin
            if (ship_placed)
            begin
                ship_idx[sel_player] <= ship_idx[sel_player] + 1'b1;
            end
            if (hit_scored)
            begin
                hits_left[sel_player] <= hits_left[sel_player] - 1'b1;
            end
        end
    end

    assign fleet_placed = (ship_idx[sel_player] == SHIP_IDX_W'(NUM_SHIPS));
    assign fleet_sunk   = (hits_left[sel_player] == '0);

    // No ship left to place once the fleet is complete
    assign ship_len = fleet_placed ? '0 : SHIP_LENGTHS[ship_idx[sel_player]];

endmodule

`default_nettype wire

// File: hdl/game_controller.sv
/*
 * Game controller
 * FSM that accepts one command at a time, runs ship placement and
 * shots against the two boards, keeps the turn and the phase, and
 * returns a one-cycle result. Placement scans the ship's path for
 * overlap before walking it again to mark the cells.
 */
`timescale 1ns/100ps
`default_nettype none

module game_controller (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   cmd_valid,
    output logic                                   cmd_ready,
    input  logic                                   player,
    input  logic                                   direction,
    input  logic [battleship_pkg::COORD_W-1:0]     row,
    input  logic [battleship_pkg::COORD_W-1:0]     col,
    output logic                                   result_valid,
    output battleship_pkg::result_t                result,
    output logic                                   game_over,
    output logic                                   winner,
    // Address walker
    output logic                                   walk_start,
    output logic                                   step,
    output logic                                   walk_dir,
    output logic [battleship_pkg::COORD_W-1:0]     start_row,
    output logic [battleship_pkg::COORD_W-1:0]     start_col,
    output logic [battleship_pkg::SHIP_LEN_W-1:0]  walk_len,
    input  logic                                   on_board,
    input  logic                                   walk_last,
    // Fleet tracker
    output logic                                   sel_player,
    output logic                                   ship_placed,
    output logic                                   hit_scored,
    input  logic [battleship_pkg::SHIP_LEN_W-1:0]  ship_len,
    input  logic                                   fleet_placed,
    input  logic                                   fleet_sunk,
    // Boards
    output logic                                   board0_write_enable,
    output logic                                   board0_read_enable,
    output battleship_pkg::cell_t                  board0_write_data,
    input  battleship_pkg::cell_t                  board0_read_data,
    output logic                                   board1_write_enable,
    output logic                                   board1_read_enable,
    output battleship_pkg::cell_t                  board1_write_data,
    input  battleship_pkg::cell_t                  board1_read_data
);
    import battleship_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE, S_CHECK, S_BOUNDS, S_READ, S_SCAN,
        S_MARK, S_SHOT, S_HIT_CHK, S_RESULT
    } state_t;

    state_t               state, next_state;
    logic                 place_phase, expected;
    logic                 game_over_q, winner_q;
    logic                 cmd_player, cmd_dir;
    logic [COORD_W-1:0]   cmd_row, cmd_col;
    result_t              result_q, res_next;
    logic                 finish, swap_turn, set_win;
    logic                 read_cell, write_cell, target;
    cell_t                cell_data, rd_data;

    // Placement works on the player's own board, shots on the opponent's
    assign target     = place_phase ? cmd_player : ~cmd_player;
    assign rd_data    = target ? board1_read_data : board0_read_data;
    assign sel_player = place_phase ? expected : ~expected;

    assign board0_read_enable  = read_cell & ~target;
    assign board1_read_enable  = read_cell & target;
    assign board0_write_enable = write_cell & ~target;
    assign board1_write_enable = write_cell & target;
    assign board0_write_data   = cell_data;
    assign board1_write_data   = cell_data;

    assign walk_dir  = cmd_dir;
    assign start_row = cmd_row;
    assign start_col = cmd_col;
    assign walk_len  = place_phase ? ship_len : SHIP_LEN_W'(1);

    assign cmd_ready    = (state == S_IDLE);
    assign result_valid = (state == S_RESULT);
    assign result       = result_q;
    assign game_over    = game_over_q;
    assign winner       = winner_q;

    // --------------------------------------------------
    // Next state and per-cycle controls
    // --------------------------------------------------
    always_comb
    begin
        next_state  = state;
        finish      = 1'b0;
        res_next    = RES_PLACED;
        walk_start  = 1'b0;
        step        = 1'b0;
        read_cell   = 1'b0;
        write_cell  = 1'b0;
        cell_data   = CELL_EMPTY;
        ship_placed = 1'b0;
        hit_scored  = 1'b0;
        swap_turn   = 1'b0;
        set_win     = 1'b0;
        case (state)
            S_IDLE:
                if (cmd_valid)
                    next_state = S_CHECK;
            S_CHECK:
            begin
                if (game_over_q)
                begin
                    finish   = 1'b1;
                    res_next = RES_GAME_OVER;
                end
                else if (cmd_player != expected)
                begin
                    finish   = 1'b1;
                    res_next = RES_WRONG_PLAYER;
                end
                else
                begin
                    walk_start = 1'b1;
                    next_state = S_BOUNDS;
                end
            end
            S_BOUNDS:
            begin
                if (!on_board)
                begin
                    finish   = 1'b1;
                    res_next = RES_OFF_BOARD;
                end
                else
                    next_state = S_READ;
            end
            S_READ:
            begin
                read_cell  = 1'b1;
                next_state = place_phase ? S_SCAN : S_SHOT;
            end
            S_SCAN:
            begin
                if (rd_data != CELL_EMPTY)
                begin
                    finish   = 1'b1;
                    res_next = RES_OVERLAP;
                end
                else if (walk_last)
                begin
                    // Path is clear so the walk restarts to mark it
                    walk_start = 1'b1;
                    next_state = S_MARK;
                end
                else
                begin
                    step       = 1'b1;
                    next_state = S_READ;
                end
            end
            S_MARK:
            begin
                write_cell = 1'b1;
                cell_data  = CELL_SHIP;
                if (walk_last)
                begin
                    ship_placed = 1'b1;
                    finish      = 1'b1;
                    res_next    = RES_PLACED;
                end
                else
                    step = 1'b1;
            end
            S_SHOT:
            begin
                case (rd_data)
                    CELL_EMPTY:
                    begin
                        write_cell = 1'b1;
                        cell_data  = CELL_MISS;
                        swap_turn  = 1'b1;
                        finish     = 1'b1;
                        res_next   = RES_MISS;
                    end
                    CELL_SHIP:
                    begin
                        write_cell = 1'b1;
                        cell_data  = CELL_HIT;
                        hit_scored = 1'b1;
                        next_state = S_HIT_CHK;
                    end
                    default:
                    begin
                        finish   = 1'b1;
                        res_next = RES_REPEAT;
                    end
                endcase
            end
            // Remaining-hits count has settled here
            S_HIT_CHK:
            begin
                finish   = 1'b1;
                set_win  = fleet_sunk;
                res_next = fleet_sunk ? RES_WIN : RES_HIT;
            end
            S_RESULT:
                next_state = S_IDLE;
            default:
                next_state = S_IDLE;
        endcase
        if (finish)
            next_state = S_RESULT;
    end

    // --------------------------------------------------
    // State, turn and phase
    // --------------------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= S_IDLE;
            place_phase <= 1'b1;
            expected    <= 1'b0;
            game_over_q <= 1'b0;
            winner_q    <= 1'b0;
        end
        else
        begin
            state <= next_state;
            if (swap_turn)
                expected <= ~expected;
            if (set_win)
            begin
                game_over_q <= 1'b1;
                winner_q    <= expected;
            end
            // Fleet count reflects the last placement by now
            if (state == S_RESULT && place_phase && fleet_placed)
            begin
                if (expected)
                begin
                    place_phase <= 1'b0;
                    expected    <= 1'b0;
                end
                else
                    expected <= 1'b1;
            end
        end
    end

    // Command fields and result
    always_ff @(posedge clk)
    begin
        if (cmd_valid && cmd_ready)
        begin
            cmd_player <= player;
            cmd_dir    <= direction;
            cmd_row    <= row;
            cmd_col    <= col;
        end
        if (finish)
            result_q <= res_next;
    end

endmodule

`default_nettype wire

// File: hdl/battleship.sv
/*
 * Battleship referee core
 * Joins the game controller, the cell walker, the fleet tracker
 * and the two player boards
 */
`timescale 1ns/100ps
`default_nettype none

module battleship (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                cmd_valid,
    output logic                                cmd_ready,
    input  logic                                player,
    input  logic                                direction,
    input  logic [battleship_pkg::COORD_W-1:0]  row,
    input  logic [battleship_pkg::COORD_W-1:0]  col,
    output logic                                result_valid,
    output battleship_pkg::result_t             result,
    output logic                                game_over,
    output logic                                winner
);
    import battleship_pkg::*;

    logic                  walk_start, step, walk_dir, on_board, walk_last;
    logic [COORD_W-1:0]    start_row, start_col, addr_row, addr_col;
    logic [SHIP_LEN_W-1:0] walk_len, ship_len;
    logic                  sel_player, ship_placed, hit_scored;
    logic                  fleet_placed, fleet_sunk;
    logic                  b0_we, b0_re, b1_we, b1_re;
    cell_t                 b0_wdata, b0_rdata, b1_wdata, b1_rdata;

    game_controller ctrl0 (
        .clk, .reset, .cmd_valid, .cmd_ready, .player, .direction,
        .row, .col, .result_valid, .result, .game_over, .winner,
        .walk_start, .step, .walk_dir, .start_row, .start_col,
        .walk_len, .on_board, .walk_last,
        .sel_player, .ship_placed, .hit_scored, .ship_len,
        .fleet_placed, .fleet_sunk,
        .board0_write_enable (b0_we),
        .board0_read_enable  (b0_re),
        .board0_write_data   (b0_wdata),
        .board0_read_data    (b0_rdata),
        .board1_write_enable (b1_we),
        .board1_read_enable  (b1_re),
        .board1_write_data   (b1_wdata),
        .board1_read_data    (b1_rdata)
    );

    cell_walker walker0 (
        .clk, .reset, .walk_start, .step,
        .direction (walk_dir),
        .start_row, .start_col,
        .ship_len  (walk_len),
        .row       (addr_row),
        .col       (addr_col),
        .on_board, .walk_last
    );

    fleet_tracker fleet0 (
        .clk, .reset, .sel_player, .ship_placed, .hit_scored,
        .ship_len, .fleet_placed, .fleet_sunk
    );

    // Both boards share the walker's address
    board_mem board0 (
        .clk, .reset,
        .write_enable (b0_we),
        .read_enable  (b0_re),
        .row          (addr_row),
        .col          (addr_col),
        .write_data   (b0_wdata),
        .read_data    (b0_rdata)
    );

    board_mem board1 (
        .clk, .reset,
        .write_enable (b1_we),
        .read_enable  (b1_re),
        .row          (addr_row),
        .col          (addr_col),
        .write_data   (b1_wdata),
        .read_data    (b1_rdata)
    );

endmodule

`default_nettype wire

// File: dv/battleship_properties.sv
/*
 * Battleship handshake properties
 * Checks the command/result handshake and the sticky game over flag
 */
`timescale 1ns/100ps
`default_nettype none

module battleship_properties (
    input  logic clk,
    input  logic reset,
    input  logic cmd_valid,
    input  logic cmd_ready,
    input  logic result_valid,
    input  logic game_over
);

    logic busy;

    // High from acceptance until the result pulse
    always_ff @(posedge clk)
    begin
        if (reset)
            busy <= 1'b0;
        else if (cmd_valid && cmd_ready)
            busy <= 1'b1;
        else if (result_valid)
            busy <= 1'b0;
    end

    a_result_pulse: assert property (
        @(posedge clk) disable iff (reset) result_valid |=> !result_valid
    ) else $error("result_valid stayed high for more than one cycle");

    a_busy_not_ready: assert property (
        @(posedge clk) disable iff (reset) busy |-> !cmd_ready
    ) else $error("cmd_ready high while a command is in progress");

    a_ready_after_result: assert property (
        @(posedge clk) disable iff (reset) result_valid |=> cmd_ready
    ) else $error("cmd_ready not back the cycle after result_valid");

    a_game_over_sticky: assert property (
        @(posedge clk) (game_over && !reset) |=> game_over
    ) else $error("game_over fell without a reset");

endmodule

bind battleship battleship_properties props0 (
    .clk          (clk),
    .reset        (reset),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .result_valid (result_valid),
    .game_over    (game_over)
);

`default_nettype wire

// File: dv/battleship_tb_table.svh
/*
 * Battleship testbench command table
 * One full game: both fleets placed with rejects mixed in,
 * then shots until player 0 sinks player 1, then late commands
 */
// Each row holds player, direction (1 horizontal), row, col,
// expected result, expected game_over and expected winner

localparam int NUM_CMDS = 47;

task automatic fill_table();
    // Player 0 fleet with lengths 5 4 3 3 2
    add_cmd(0, 0,  2,  5, RES_PLACED,       0, 0);
    add_cmd(0, 1,  4,  3, RES_OVERLAP,      0, 0);
    add_cmd(1, 1,  5,  5, RES_WRONG_PLAYER, 0, 0);
    add_cmd(0, 1,  1,  7, RES_OFF_BOARD,    0, 0);
    add_cmd(0, 1,  9,  6, RES_PLACED,       0, 0);
    add_cmd(0, 0,  8,  3, RES_OFF_BOARD,    0, 0);
    add_cmd(0, 0,  7,  0, RES_PLACED,       0, 0);
    add_cmd(0, 1,  0,  7, RES_PLACED,       0, 0);
    add_cmd(0, 0,  0,  0, RES_PLACED,       0, 0);
    // Player 1 fleet
    add_cmd(0, 1,  3,  3, RES_WRONG_PLAYER, 0, 0);
    add_cmd(1, 1,  0,  5, RES_PLACED,       0, 0);
    add_cmd(1, 0,  0,  9, RES_OVERLAP,      0, 0);
    add_cmd(1, 0,  6,  9, RES_PLACED,       0, 0);
    add_cmd(1, 0,  9,  5, RES_OFF_BOARD,    0, 0);
    add_cmd(1, 1,  5,  0, RES_PLACED,       0, 0);
    add_cmd(1, 0,  1,  3, RES_PLACED,       0, 0);
    add_cmd(1, 1,  9,  0, RES_PLACED,       0, 0);
    // Turn passing, repeats and off-board shots
    add_cmd(0, 0,  4,  4, RES_MISS,         0, 0);
    add_cmd(0, 0,  0,  5, RES_WRONG_PLAYER, 0, 0);
    add_cmd(1, 0,  2,  5, RES_HIT,          0, 0);
    add_cmd(1, 0,  2,  5, RES_REPEAT,       0, 0);
    add_cmd(1, 0, 10,  2, RES_OFF_BOARD,    0, 0);
    add_cmd(1, 0,  3, 15, RES_OFF_BOARD,    0, 0);
    add_cmd(1, 0,  4,  4, RES_MISS,         0, 0);
    add_cmd(0, 0,  4,  4, RES_REPEAT,       0, 0);
    // Player 0 sinks the whole of player 1's fleet
    add_cmd(0, 0,  0,  5, RES_HIT,          0, 0);
    add_cmd(0, 0,  0,  6, RES_HIT,          0, 0);
    add_cmd(0, 0,  0,  7, RES_HIT,          0, 0);
    add_cmd(0, 0,  0,  8, RES_HIT,          0, 0);
    add_cmd(0, 0,  0,  9, RES_HIT,          0, 0);
    add_cmd(1, 0,  0,  0, RES_WRONG_PLAYER, 0, 0);
    add_cmd(0, 0,  0,  5, RES_REPEAT,       0, 0);
    add_cmd(0, 0,  6,  9, RES_HIT,          0, 0);
    add_cmd(0, 0,  7,  9, RES_HIT,          0, 0);
    add_cmd(0, 0,  8,  9, RES_HIT,          0, 0);
    add_cmd(0, 0,  9,  9, RES_HIT,          0, 0);
    add_cmd(0, 0,  5,  0, RES_HIT,          0, 0);
    add_cmd(0, 0,  5,  1, RES_HIT,          0, 0);
    add_cmd(0, 0,  5,  2, RES_HIT,          0, 0);
    add_cmd(0, 0,  1,  3, RES_HIT,          0, 0);
    add_cmd(0, 0,  2,  3, RES_HIT,          0, 0);
    add_cmd(0, 0,  3,  3, RES_HIT,          0, 0);
    add_cmd(0, 0,  9,  0, RES_HIT,          0, 0);
    add_cmd(0, 0,  9,  1, RES_WIN,          1, 0);
    // Nothing is played after the win
    add_cmd(1, 0,  0,  0, RES_GAME_OVER,    1, 0);
    add_cmd(0, 0,  4,  4, RES_GAME_OVER,    1, 0);
    add_cmd(0, 1, 12, 12, RES_GAME_OVER,    1, 0);
endtask

// File: dv/battleship_tb.sv
/*
 * Battleship referee testbench
 * Plays a scripted game from a command table, one handshake per row,
 * and checks each result, game_over and winner against the table
 */
`timescale 1ns/100ps
`default_nettype none

module battleship_tb;
    import battleship_pkg::*;

    localparam int CLK_HALF     = 20;
    localparam int RESET_CYCLES = 8;
    localparam int CMD_CYCLES   = 40;

    typedef struct packed {
        logic               player;
        logic               direction;
        logic [COORD_W-1:0] row;
        logic [COORD_W-1:0] col;
        result_t            exp_result;
        logic               exp_game_over;
        logic               exp_winner;
    } cmd_entry_t;

    `include "battleship_tb_table.svh"

    localparam int TIMEOUT_CYCLES = NUM_CMDS * CMD_CYCLES + RESET_CYCLES;

    logic               clk = 1'b0;
    logic               reset;
    logic               cmd_valid;
    logic               cmd_ready;
    logic               player;
    logic               direction;
    logic [COORD_W-1:0] row;
    logic [COORD_W-1:0] col;
    logic               result_valid;
    result_t            result;
    logic               game_over;
    logic               winner;

    cmd_entry_t cmd_table [NUM_CMDS];
    int         fill_count  = 0;
    int         cycle_count = 0;
    integer     seed;

    battleship dut0 (
        .clk, .reset, .cmd_valid, .cmd_ready, .player, .direction,
        .row, .col, .result_valid, .result, .game_over, .winner
    );

    always #CLK_HALF clk = ~clk;

    // --------------------------------------------------
    // Error handling and compare tasks
    // --------------------------------------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_result(input result_t actual, input result_t expected, input int index);
        if (actual !== expected)
            abort_run($sformatf("FAIL @ %0t: command %0d gave result %s, expected %s",
                                $time, index, actual.name(), expected.name()));
    endtask

    task automatic check_flag(input string what, input logic actual, input logic expected,
                              input int index);
        if (actual !== expected)
            abort_run($sformatf("FAIL @ %0t: command %0d gave %s = %b, expected %b",
                                $time, index, what, actual, expected));
    endtask

    task automatic add_cmd(input int p, input int d, input int r, input int c,
                           input result_t res, input int go, input int win);
        cmd_entry_t entry;
        entry.player        = 1'(p);
        entry.direction     = 1'(d);
        entry.row           = COORD_W'(r);
        entry.col           = COORD_W'(c);
        entry.exp_result    = res;
        entry.exp_game_over = 1'(go);
        entry.exp_winner    = 1'(win);
        if (fill_count < NUM_CMDS)
            cmd_table[fill_count] = entry;
        fill_count++;
    endtask

    // --------------------------------------------------
    // One command: idle gap, handshake, result check
    // --------------------------------------------------
    task automatic run_command(input cmd_entry_t entry, input int index);
        int   idle;
        logic accepted;
        logic got;
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) @(posedge clk);
        cmd_valid <= 1'b1;
        player    <= entry.player;
        direction <= entry.direction;
        row       <= entry.row;
        col       <= entry.col;
        // Ready is sampled mid-cycle and the next edge takes the command
        accepted = 1'b0;
        while (!accepted)
        begin
            @(negedge clk);
            accepted = cmd_ready;
            @(posedge clk);
        end
        cmd_valid <= 1'b0;
        got = 1'b0;
        while (!got)
        begin
            @(negedge clk);
            got = result_valid;
        end
        check_result(result, entry.exp_result, index);
        check_flag("game_over", game_over, entry.exp_game_over, index);
        check_flag("winner", winner, entry.exp_winner, index);
        @(posedge clk);
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run($sformatf("Timeout: no result after %0d clock cycles", cycle_count));
    end

    initial
    begin
        seed      = 46;
        reset     = 1'b1;
        cmd_valid = 1'b0;
        player    = 1'b0;
        direction = 1'b0;
        row       = '0;
        col       = '0;
        fill_table();
        if (fill_count != NUM_CMDS)
            abort_run($sformatf("Command table holds %0d rows but NUM_CMDS is %0d",
                                fill_count, NUM_CMDS));
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < NUM_CMDS; i++)
        begin
            run_command(cmd_table[i], i);
        end
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// File: battleship.f
+incdir+dv
hdl/battleship_pkg.sv
hdl/board_mem.sv
hdl/cell_walker.sv
hdl/fleet_tracker.sv
hdl/game_controller.sv
hdl/battleship.sv
dv/battleship_properties.sv
dv/battleship_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the battleship testbench with Verilator, run it and judge the log

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module battleship_tb -f battleship.f \
    -Mdir obj_dir -o battleship_sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/battleship_sim > "$LOG" 2>&1

grep -q "FAIL: see errors above" "$LOG" \
    && { echo "Simulation failed, see $LOG"; exit 1; }

grep -q "PASS: all tests" "$LOG" \
    || { echo "Simulation stopped without a result, see $LOG"; exit 1; }

echo "Simulation passed"
exit 0
